//--- rtl/eth_rx_pkg.sv
package eth_rx_pkg;

  // ----------------------------------------
  // Buffer geometry
  // ----------------------------------------
  localparam int NUM_SLOTS        = 2;
  localparam int SLOT_IDX_W       = $clog2(NUM_SLOTS);
  localparam int SLOT_WORD_ADDR_W = 11;
  localparam int WORD_W           = 16;
  localparam int RAM_ADDR_W       = SLOT_IDX_W + SLOT_WORD_ADDR_W;
  localparam int RAM_WORDS        = NUM_SLOTS << SLOT_WORD_ADDR_W;

  // Word 0 is the length header, word 1 is reserved
  localparam int HDR_WORDS        = 2;
  localparam int MAX_FRAME_BYTES  = 1518;

  // ----------------------------------------
  // Descriptor fields and counters
  // ----------------------------------------
  localparam int TS_W             = 32;
  localparam int LEN_W            = 12;
  localparam int DROP_CNT_W       = 16;
  localparam int DESC_CNT_W       = $clog2(NUM_SLOTS + 1);

  // Writer FSM encoding
  localparam int              WR_ST_W  = 3;
  localparam logic [WR_ST_W-1:0] WR_IDLE  = 3'd0;
  localparam logic [WR_ST_W-1:0] WR_ARMED = 3'd1;
  localparam logic [WR_ST_W-1:0] WR_RECV  = 3'd2;
  localparam logic [WR_ST_W-1:0] WR_HDR   = 3'd3;
  localparam logic [WR_ST_W-1:0] WR_DONE  = 3'd4;

  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

  // One slot word, seen as two byte lanes or as the frame header
  typedef union packed {
    struct packed {
      logic [7:0] hi_byte;
      logic [7:0] lo_byte;
    } lanes;
    struct packed {
      logic             too_long;
      logic [2:0]       spare;
      logic [LEN_W-1:0] len;
    } hdr;
  } slot_word_u;

endpackage

//--- rtl/eth_rx_if.sv
`timescale 1ns/1ps
`default_nettype none

// Word write port from the GMII writer into the slot RAM
interface slot_wr_if;
  import eth_rx_pkg::*;

  logic                        wr_en;
  slot_idx_t                   slot;
  logic [SLOT_WORD_ADDR_W-1:0] addr;
  logic [1:0]                  byte_en;
  slot_word_u                  data;

  modport writer (output wr_en, slot, addr, byte_en, data);
  modport mem    (input  wr_en, slot, addr, byte_en, data);

endinterface

// Completion report for one stored frame
interface frame_done_if;
  import eth_rx_pkg::*;

  logic             done;
  slot_idx_t        slot;
  logic [LEN_W-1:0] len;
  logic             too_long;
  logic [TS_W-1:0]  timestamp;

  // done is a single-cycle pulse, the other fields hold until the next frame
  modport src (output done, slot, len, too_long, timestamp);
  modport dst (input  done, slot, len, too_long, timestamp);

endinterface

`default_nettype wire

//--- rtl/gmii_rx_slot_writer.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_rx_slot_writer (
  input  logic                          gmii_rx_clk,
  input  logic                          sys_rst,
  input  logic [7:0]                    gmii_rxd,
  input  logic                          gmii_rx_dv,
  input  logic [eth_rx_pkg::TS_W-1:0]   timestamp,
  input  logic                          credit_avail,
  input  eth_rx_pkg::slot_idx_t         credit_slot,
  output logic                          credit_take,
  output logic                          frame_drop,
  slot_wr_if.writer                     wr,
  frame_done_if.src                     fd
);
  import eth_rx_pkg::*;

  logic [WR_ST_W-1:0] state;
  logic               hdr_sel;
  logic               dv_q;
  slot_idx_t          cur_slot;
  logic [LEN_W-1:0]   byte_cnt;
  logic               too_long;
  logic               frame_start;
  logic               byte_fits;
  logic               byte_in;

  // Arm only between frames with a free slot on offer
  assign credit_take = !sys_rst && (state == WR_IDLE) && !gmii_rx_dv && credit_avail;

  assign frame_start = gmii_rx_dv && !dv_q;
  assign byte_fits   = byte_cnt < LEN_W'(MAX_FRAME_BYTES);
  assign byte_in     = gmii_rx_dv && ((state == WR_ARMED) || (state == WR_RECV));

  assign wr.slot     = cur_slot;
  assign fd.slot     = cur_slot;
  assign fd.len      = byte_cnt;
  assign fd.too_long = too_long;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  // After dv falls the header takes two cycles and done one more,
  // so a frame needs five idle cycles in front of it to be accepted
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      state      <= WR_IDLE;
      hdr_sel    <= 1'b0;
      dv_q       <= 1'b0;
      byte_cnt   <= '0;
      too_long   <= 1'b0;
      wr.wr_en   <= 1'b0;
      fd.done    <= 1'b0;
      frame_drop <= 1'b0;
    end else begin
      dv_q       <= gmii_rx_dv;
      wr.wr_en   <= 1'b0;
      fd.done    <= 1'b0;
      // Any frame that does not start in the armed state is lost
      frame_drop <= frame_start && (state != WR_ARMED);

      case (state)
        WR_IDLE: begin
          if (credit_take) begin
            state    <= WR_ARMED;
            byte_cnt <= '0;
            too_long <= 1'b0;
          end
        end
        WR_ARMED, WR_RECV: begin
          if (gmii_rx_dv) begin
            state <= WR_RECV;
            if (byte_fits) begin
              wr.wr_en <= 1'b1;
            end else begin
              too_long <= 1'b1;
            end
            // Length saturates at the top of the field
            if (byte_cnt != '1) begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end else if (state == WR_RECV) begin
            state   <= WR_HDR;
            hdr_sel <= 1'b0;
          end
        end
        WR_HDR: begin
          wr.wr_en <= 1'b1;
          hdr_sel  <= 1'b1;
          if (hdr_sel) begin
            state <= WR_DONE;
          end
        end
        WR_DONE: begin
          fd.done <= 1'b1;
          state   <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Write datapath
  // ----------------------------------------
  always_ff @(posedge gmii_rx_clk) begin
    if (credit_take) begin
      cur_slot <= credit_slot;
    end
    // Timestamp of the first byte
    if (gmii_rx_dv && (state == WR_ARMED)) begin
      fd.timestamp <= timestamp;
    end

    if (byte_in) begin
      wr.addr <= SLOT_WORD_ADDR_W'(HDR_WORDS + (byte_cnt >> 1));
      // Even bytes in the low lane, odd bytes in the high lane
      if (byte_cnt[0]) begin
        wr.byte_en             <= 2'b10;
        wr.data.lanes.hi_byte  <= gmii_rxd;
        wr.data.lanes.lo_byte  <= 8'h00;
      end else begin
        wr.byte_en             <= 2'b01;
        wr.data.lanes.hi_byte  <= 8'h00;
        wr.data.lanes.lo_byte  <= gmii_rxd;
      end
    end else if (state == WR_HDR) begin
      wr.addr    <= SLOT_WORD_ADDR_W'(hdr_sel);
      wr.byte_en <= 2'b11;
      if (hdr_sel) begin
        wr.data <= '0;
      end else begin
        wr.data.hdr.too_long <= too_long;
        wr.data.hdr.spare    <= '0;
        wr.data.hdr.len      <= byte_cnt;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rx_slot_ram.sv
`timescale 1ns/1ps
`default_nettype none

module rx_slot_ram (
  input  logic                                    gmii_rx_clk,
  input  logic                                    sys_rst,
  slot_wr_if.mem                                  wr,
  input  eth_rx_pkg::slot_idx_t                   rd_slot,
  input  logic [eth_rx_pkg::SLOT_WORD_ADDR_W-1:0] rd_addr,
  output logic [eth_rx_pkg::WORD_W-1:0]           rd_data
);
  import eth_rx_pkg::*;

  slot_word_u mem [RAM_WORDS];

  logic [RAM_ADDR_W-1:0] wr_idx;
  logic [RAM_ADDR_W-1:0] rd_idx;

  // Slot number selects the upper half of the word address
  assign wr_idx = {wr.slot, wr.addr};
  assign rd_idx = {rd_slot, rd_addr};

  // Byte lane writes
  always_ff @(posedge gmii_rx_clk) begin
    if (wr.wr_en) begin
      if (wr.byte_en[0]) begin
        mem[wr_idx].lanes.lo_byte <= wr.data.lanes.lo_byte;
      end
      if (wr.byte_en[1]) begin
        mem[wr_idx].lanes.hi_byte <= wr.data.lanes.hi_byte;
      end
    end
  end

  // Host read, one cycle latency
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

//--- rtl/rx_slot_manager.sv
`timescale 1ns/1ps
`default_nettype none

module rx_slot_manager (
  input  logic                              gmii_rx_clk,
  input  logic                              sys_rst,
  input  logic                              credit_take,
  input  logic                              frame_drop,
  input  logic                              desc_release,
  frame_done_if.dst                         fd,
  output logic [eth_rx_pkg::TS_W-1:0]       timestamp,
  output logic                              credit_avail,
  output eth_rx_pkg::slot_idx_t             credit_slot,
  output logic                              desc_valid,
  output eth_rx_pkg::slot_idx_t             desc_slot,
  output logic [eth_rx_pkg::LEN_W-1:0]      desc_len,
  output logic                              desc_too_long,
  output logic [eth_rx_pkg::TS_W-1:0]       desc_timestamp,
  output logic [eth_rx_pkg::DROP_CNT_W-1:0] rx_drop_count
);
  import eth_rx_pkg::*;

  // Bit set means the slot is free and may be handed out
  logic [NUM_SLOTS-1:0]  free_map;

  slot_idx_t             q_slot     [NUM_SLOTS];
  logic [LEN_W-1:0]      q_len      [NUM_SLOTS];
  logic                  q_too_long [NUM_SLOTS];
  logic [TS_W-1:0]       q_ts       [NUM_SLOTS];
  slot_idx_t             wr_ptr;
  slot_idx_t             rd_ptr;
  logic [DESC_CNT_W-1:0] q_count;
  logic                  push;
  logic                  pop;

  function automatic slot_idx_t next_ptr(input slot_idx_t ptr);
    if (ptr == slot_idx_t'(NUM_SLOTS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = fd.done;
  assign pop  = desc_release && desc_valid;

  // Free-running receive time base
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      timestamp <= '0;
    end else begin
      timestamp <= timestamp + 1'b1;
    end
  end

  // ----------------------------------------
  // Credit pool
  // ----------------------------------------
  assign credit_avail = |free_map;

  // Lowest free slot goes first
  always_comb begin
    credit_slot = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (free_map[i]) begin
        credit_slot = slot_idx_t'(i);
      end
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      free_map <= '1;
    end else begin
      if (credit_take) begin
        free_map[credit_slot] <= 1'b0;
      end
      // Releasing a descriptor hands its slot back
      if (pop) begin
        free_map[desc_slot] <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Descriptor queue
  // ----------------------------------------
  always_ff @(posedge gmii_rx_clk) begin
    if (push) begin
      q_slot[wr_ptr]     <= fd.slot;
      q_len[wr_ptr]      <= fd.len;
      q_too_long[wr_ptr] <= fd.too_long;
      q_ts[wr_ptr]       <= fd.timestamp;
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  assign desc_valid     = q_count != '0;
  assign desc_slot      = q_slot[rd_ptr];
  assign desc_len       = q_len[rd_ptr];
  assign desc_too_long  = q_too_long[rd_ptr];
  assign desc_timestamp = q_ts[rd_ptr];

  // Frames lost for lack of a slot
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      rx_drop_count <= '0;
    end else if (frame_drop) begin
      rx_drop_count <= rx_drop_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/eth_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top (
  input  logic                                    gmii_rx_clk,
  input  logic                                    sys_rst,
  input  logic [7:0]                              gmii_rxd,
  input  logic                                    gmii_rx_dv,
  // Descriptor queue head
  output logic                                    desc_valid,
  output eth_rx_pkg::slot_idx_t                   desc_slot,
  output logic [eth_rx_pkg::LEN_W-1:0]            desc_len,
  output logic                                    desc_too_long,
  output logic [eth_rx_pkg::TS_W-1:0]             desc_timestamp,
  input  logic                                    desc_release,
  // Slot read port
  input  eth_rx_pkg::slot_idx_t                   rd_slot,
  input  logic [eth_rx_pkg::SLOT_WORD_ADDR_W-1:0] rd_addr,
  output logic [eth_rx_pkg::WORD_W-1:0]           rd_data,
  output logic [eth_rx_pkg::DROP_CNT_W-1:0]       rx_drop_count
);
  import eth_rx_pkg::*;

  logic [TS_W-1:0] timestamp;
  logic            credit_avail;
  slot_idx_t       credit_slot;
  logic            credit_take;
  logic            frame_drop;

  slot_wr_if    i_slot_wr ();
  frame_done_if i_frame_done ();

  gmii_rx_slot_writer i_writer (
    .gmii_rx_clk  (gmii_rx_clk),
    .sys_rst      (sys_rst),
    .gmii_rxd     (gmii_rxd),
    .gmii_rx_dv   (gmii_rx_dv),
    .timestamp    (timestamp),
    .credit_avail (credit_avail),
    .credit_slot  (credit_slot),
    .credit_take  (credit_take),
    .frame_drop   (frame_drop),
    .wr           (i_slot_wr),
    .fd           (i_frame_done)
  );

  rx_slot_ram i_ram (
    .gmii_rx_clk (gmii_rx_clk),
    .sys_rst     (sys_rst),
    .wr          (i_slot_wr),
    .rd_slot     (rd_slot),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  rx_slot_manager i_manager (
    .gmii_rx_clk    (gmii_rx_clk),
    .sys_rst        (sys_rst),
    .credit_take    (credit_take),
    .frame_drop     (frame_drop),
    .desc_release   (desc_release),
    .fd             (i_frame_done),
    .timestamp      (timestamp),
    .credit_avail   (credit_avail),
    .credit_slot    (credit_slot),
    .desc_valid     (desc_valid),
    .desc_slot      (desc_slot),
    .desc_len       (desc_len),
    .desc_too_long  (desc_too_long),
    .desc_timestamp (desc_timestamp),
    .rx_drop_count  (rx_drop_count)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic gmii_rx_clk,
  output logic sys_rst
);

  localparam time HALF_PERIOD = 50ns;
  localparam int  RST_CYCLES  = 8;

  initial begin
    gmii_rx_clk = 1'b0;
    forever #HALF_PERIOD gmii_rx_clk = ~gmii_rx_clk;
  end

  // Reset released on a rising edge after RST_CYCLES edges
  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge gmii_rx_clk);
    sys_rst <= 1'b0;
  end

endmodule

//--- verification/eth_rx_props.sv
`timescale 1ns/1ps

module eth_rx_props (
  input logic                                gmii_rx_clk,
  input logic                                sys_rst,
  input logic                                credit_take,
  input logic                                credit_avail,
  input logic                                desc_valid,
  input logic                                push,
  input logic                                pop,
  input logic [eth_rx_pkg::DESC_CNT_W-1:0]   q_count
);
  import eth_rx_pkg::*;

  // Slots handed to the writer and not yet returned by the host
  int held;
  // Descriptors pushed and not yet popped
  int queued;

  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      held   <= 0;
      queued <= 0;
    end else begin
      held   <= held + (credit_take ? 1 : 0) - (pop ? 1 : 0);
      queued <= queued + (push ? 1 : 0) - (pop ? 1 : 0);
    end
  end

  // No credit on offer while every slot is held
  assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    (held == NUM_SLOTS) |-> !credit_avail)
    else $error("credit offered while all slots are held");

  assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    desc_valid |-> (queued != 0))
    else $error("descriptor valid with an empty queue");

  // A push into a full queue must be matched by a pop
  assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    ((q_count == DESC_CNT_W'(NUM_SLOTS)) && push) |-> pop)
    else $error("descriptor queue overflow");

endmodule

bind rx_slot_manager eth_rx_props i_props (
  .gmii_rx_clk  (gmii_rx_clk),
  .sys_rst      (sys_rst),
  .credit_take  (credit_take),
  .credit_avail (credit_avail),
  .desc_valid   (desc_valid),
  .push         (push),
  .pop          (pop),
  .q_count      (q_count)
);

//--- verification/eth_rx_checker.sv
`timescale 1ns/1ps

module eth_rx_checker (
  input  logic                                    gmii_rx_clk,
  input  logic                                    desc_valid,
  input  eth_rx_pkg::slot_idx_t                   desc_slot,
  input  logic [eth_rx_pkg::LEN_W-1:0]            desc_len,
  input  logic                                    desc_too_long,
  input  logic [eth_rx_pkg::TS_W-1:0]             desc_timestamp,
  input  logic [eth_rx_pkg::WORD_W-1:0]           rd_data,
  input  logic [eth_rx_pkg::DROP_CNT_W-1:0]       rx_drop_count,
  output logic                                    desc_release,
  output eth_rx_pkg::slot_idx_t                   rd_slot,
  output logic [eth_rx_pkg::SLOT_WORD_ADDR_W-1:0] rd_addr
);
  import eth_rx_pkg::*;

  localparam int MAX_REC = 16;
  localparam int TIMEOUT = 20000;

  // Expected frames, filled in by the testbench top
  logic [7:0]  exp_byte [NUM_SLOTS][MAX_FRAME_BYTES];
  int          rec_len  [MAX_REC];
  logic [31:0] rec_ts   [MAX_REC];
  int          rec_slot [MAX_REC];
  bit          rec_drop [MAX_REC];
  int          n_posted   = 0;
  bit          posted_all = 0;
  int          rel_req    = 0;

  int   rel_done   = 0;
  int   nd_checked = 0;
  int   drops_exp  = 0;
  int   err_cnt    = 0;
  bit   abort      = 0;
  bit   all_done   = 0;
  logic rel_go     = 1'b0;
  logic rel_pulse  = 1'b0;

  assign desc_release = rel_pulse;

  task automatic compare(input int idx, input string sig, input logic [31:0] exp_v,
                         input logic [31:0] got_v, inout int bad);
    if (exp_v !== got_v) begin
      $display("MISMATCH frame %0d %s exp 0x%0h got 0x%0h", idx, sig, exp_v, got_v);
      bad++;
    end
  endtask

  // Registered read port, data sampled one cycle after the address
  task automatic read_word(input int slot, input int addr, output slot_word_u w);
    @(posedge gmii_rx_clk);
    rd_slot <= slot_idx_t'(slot);
    rd_addr <= SLOT_WORD_ADDR_W'(addr);
    @(posedge gmii_rx_clk);
    @(negedge gmii_rx_clk);
    w = rd_data;
  endtask

  task automatic check_frame(input int i);
    int         bad;
    int         tmo;
    int         nb;
    int         slot;
    int         exp_len;
    bit         exp_long;
    slot_word_u w;
    bad  = 0;
    tmo  = 0;
    slot = rec_slot[i];
    // Head must be a fresh descriptor, not one already checked
    while (!(desc_valid && (rel_done == nd_checked))) begin
      @(negedge gmii_rx_clk);
      tmo++;
      if (tmo > TIMEOUT) begin
        $display("TIMEOUT: no descriptor arrived for frame %0d", i);
        err_cnt++;
        abort = 1;
        return;
      end
    end
    exp_long = rec_len[i] > MAX_FRAME_BYTES;
    exp_len  = (rec_len[i] > 4095) ? 4095 : rec_len[i];
    nb       = exp_long ? MAX_FRAME_BYTES : rec_len[i];
    compare(i, "desc_slot", slot, 32'(desc_slot), bad);
    compare(i, "desc_len", exp_len, 32'(desc_len), bad);
    compare(i, "desc_too_long", 32'(exp_long), 32'(desc_too_long), bad);
    compare(i, "desc_timestamp", rec_ts[i], desc_timestamp, bad);
    read_word(slot, 0, w);
    compare(i, "hdr.len", exp_len, 32'(w.hdr.len), bad);
    compare(i, "hdr.too_long", 32'(exp_long), 32'(w.hdr.too_long), bad);
    read_word(slot, 1, w);
    compare(i, "word 1", 0, 32'(w), bad);
    for (int k = 0; k < nb; k += 2) begin
      read_word(slot, HDR_WORDS + k / 2, w);
      compare(i, "lo_byte", 32'(exp_byte[slot][k]), 32'(w.lanes.lo_byte), bad);
      // Odd length leaves the high lane of the last word unwritten
      if (k + 1 < nb) begin
        compare(i, "hi_byte", 32'(exp_byte[slot][k+1]), 32'(w.lanes.hi_byte), bad);
      end
    end
    nd_checked++;
    err_cnt += bad;
    $display("frame %0d: len %0d slot %0d, %0d errors", i, rec_len[i], slot, bad);
  endtask

  task automatic check_drop(input int i);
    int tmo;
    tmo = 0;
    drops_exp++;
    while (rx_drop_count != DROP_CNT_W'(drops_exp)) begin
      @(negedge gmii_rx_clk);
      tmo++;
      if (tmo > TIMEOUT) begin
        $display("frame %0d: drop counter did not reach %0d", i, drops_exp);
        err_cnt++;
        abort = 1;
        return;
      end
    end
    $display("frame %0d: len %0d dropped, drop count %0d", i, rec_len[i], drops_exp);
  endtask

  initial begin
    int i;
    int idle;
    i       = 0;
    idle    = 0;
    rd_slot = '0;
    rd_addr = '0;
    while (!abort && !(posted_all && (i >= n_posted))) begin
      if (i < n_posted) begin
        if (rec_drop[i]) begin
          check_drop(i);
        end else begin
          check_frame(i);
        end
        i++;
        idle = 0;
      end else begin
        @(negedge gmii_rx_clk);
        idle++;
        if (idle > TIMEOUT) begin
          $display("TIMEOUT: no further frames were posted");
          err_cnt++;
          abort = 1;
        end
      end
    end
    // Drops of stored frames only show in the final total
    if (!abort && (rx_drop_count !== DROP_CNT_W'(drops_exp))) begin
      $display("MISMATCH rx_drop_count exp 0x%0h got 0x%0h", drops_exp, rx_drop_count);
      err_cnt++;
    end
    $display("checked %0d frames, %0d drops, %0d errors", nd_checked, drops_exp, err_cnt);
    all_done = 1;
  end

  // ----------------------------------------
  // Host release of the checked head
  // ----------------------------------------
  always @(negedge gmii_rx_clk) begin
    rel_go <= (rel_req > rel_done) && (nd_checked > rel_done) && desc_valid;
  end

  always @(posedge gmii_rx_clk) begin
    if (rel_pulse) begin
      rel_pulse <= 1'b0;
      rel_done  <= rel_done + 1;
    end else if (rel_go) begin
      rel_pulse <= 1'b1;
    end
  end

endmodule

//--- verification/tb_eth_rx.sv
`timescale 1ns/1ps

module tb_eth_rx;
  import eth_rx_pkg::*;

  localparam int          NUM_ROWS    = 6;
  localparam int          TIMEOUT     = 20000;
  // Header writes and done pulse after dv falls
  localparam int          TAIL_CYCLES = 4;
  localparam logic [31:0] SEED        = 32'hae9a;

  // Frame length, idle gap, release before next, expect drop
  int tbl [NUM_ROWS][4] = '{
    '{64,   10, 0, 0},
    '{100,  10, 0, 0},
    '{70,   10, 1, 1},
    '{90,   10, 1, 0},
    '{1600, 10, 1, 0},
    '{61,   2,  1, 0}
  };

  logic                        gmii_rx_clk;
  logic                        sys_rst;
  logic [7:0]                  gmii_rxd;
  logic                        gmii_rx_dv;
  logic                        desc_valid;
  slot_idx_t                   desc_slot;
  logic [LEN_W-1:0]            desc_len;
  logic                        desc_too_long;
  logic [TS_W-1:0]             desc_timestamp;
  logic                        desc_release;
  slot_idx_t                   rd_slot;
  logic [SLOT_WORD_ADDR_W-1:0] rd_addr;
  logic [WORD_W-1:0]           rd_data;
  logic [DROP_CNT_W-1:0]       rx_drop_count;

  logic [31:0] lfsr;
  logic [31:0] cyc;
  int          armed;
  bit          stalled;
  bit          slot_free [NUM_SLOTS];
  int          held_q [$];

  tb_clock_gen i_clk (.gmii_rx_clk(gmii_rx_clk), .sys_rst(sys_rst));

  eth_rx_top i_dut (.*);

  eth_rx_checker i_check (.*);

  // Cycle count from reset release
  always @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int lowest_free();
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (slot_free[s]) begin
        return s;
      end
    end
    return -1;
  endfunction

  task automatic flag_timeout(input string what);
    $display("TIMEOUT: %s", what);
    stalled = 1;
  endtask

  // Writer takes the lowest free slot whenever it is idle
  task automatic arm_writer();
    armed = lowest_free();
    if (armed >= 0) begin
      slot_free[armed] = 0;
    end
  endtask

  task automatic send_frame(input int slot, input int len, output logic [31:0] ts);
    logic [7:0] b;
    for (int k = 0; k < len; k++) begin
      for (int n = 0; n < 8; n++) begin
        b[n] = lfsr[0];
        lfsr = lfsr_step(lfsr);
      end
      @(posedge gmii_rx_clk);
      gmii_rx_dv <= 1'b1;
      gmii_rxd   <= b;
      if (slot >= 0 && k < MAX_FRAME_BYTES) begin
        i_check.exp_byte[slot][k] = b;
      end
      if (k == 0) begin
        @(negedge gmii_rx_clk);
        ts = cyc;
      end
    end
    @(posedge gmii_rx_clk);
    gmii_rx_dv <= 1'b0;
    gmii_rxd   <= 8'h00;
  endtask

  task automatic release_head();
    int target;
    int tmo;
    slot_free[held_q.pop_front()] = 1;
    if (armed < 0) begin
      arm_writer();
    end
    target = i_check.rel_req + 1;
    i_check.rel_req = target;
    tmo = 0;
    while (!stalled && (i_check.rel_done < target)) begin
      @(negedge gmii_rx_clk);
      tmo++;
      if (tmo > TIMEOUT) begin
        flag_timeout("descriptor release was never performed");
      end
    end
  endtask

  initial begin
    int          tmo;
    int          slot;
    logic [31:0] ts;
    gmii_rx_dv = 1'b0;
    gmii_rxd   = 8'h00;
    lfsr       = SEED;
    stalled    = 0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      slot_free[s] = 1;
    end
    tmo = 0;
    while (!stalled && (sys_rst !== 1'b0)) begin
      @(negedge gmii_rx_clk);
      tmo++;
      if (tmo > TIMEOUT) begin
        flag_timeout("reset never released");
      end
    end
    arm_writer();

    for (int r = 0; r < NUM_ROWS && !stalled; r++) begin
      repeat (tbl[r][1]) @(posedge gmii_rx_clk);
      slot = (tbl[r][3] != 0) ? -1 : armed;
      send_frame(slot, tbl[r][0], ts);
      repeat (TAIL_CYCLES) @(posedge gmii_rx_clk);
      i_check.rec_len[r]  = tbl[r][0];
      i_check.rec_ts[r]   = ts;
      i_check.rec_slot[r] = slot;
      i_check.rec_drop[r] = tbl[r][3] != 0;
      i_check.n_posted    = r + 1;
      if (slot >= 0) begin
        held_q.push_back(slot);
        arm_writer();
      end
      if (tbl[r][2] != 0) begin
        release_head();
      end
    end
    while (!stalled && (held_q.size() > 0)) begin
      release_head();
    end
    i_check.posted_all = 1;

    tmo = 0;
    while (!stalled && !i_check.all_done) begin
      @(negedge gmii_rx_clk);
      tmo++;
      if (tmo > TIMEOUT) begin
        flag_timeout("checker did not finish");
      end
    end
    if (!stalled && (i_check.err_cnt == 0)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- tb.f
rtl/eth_rx_pkg.sv
rtl/eth_rx_if.sv
rtl/gmii_rx_slot_writer.sv
rtl/rx_slot_ram.sv
rtl/rx_slot_manager.sv
rtl/eth_rx_top.sv
verification/tb_clock_gen.sv
verification/eth_rx_props.sv
verification/eth_rx_checker.sv
verification/tb_eth_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GMII receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=Vtb_eth_rx

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_eth_rx -f tb.f --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
